/* rtl/ecfg_config.svh */
// link config block parameters
`ifndef ECFG_CONFIG_SVH
`define ECFG_CONFIG_SVH

// ########################################
// address map
// ########################################
`define ECFG_GROUP   4'h0        // compared with mi_addr[19:16]
`define ECFG_RFAW    4           // word index width, mi_addr[5:2]

// register word indices
`define ECFG_TXCFG   4'd0        // tx config
`define ECFG_TXDOUT  4'd1        // tx data-out pins
`define ECFG_TXSTAT  4'd2        // tx sticky debug, read only
`define ECFG_RXCFG   4'd4        // rx config
`define ECFG_RXGPIO  4'd5        // synced rx pin sample, read only
`define ECFG_RXSTAT  4'd6        // rx sticky debug, read only

// ########################################
// register widths
// ########################################
`define ECFG_TXCFG_W 10          // enable thru remap_enable
`define ECFG_DOUT_W  9           // link pins, also used for rx sample
`define ECFG_STAT_W  3           // sticky debug flags
`define ECFG_RXCFG_W 6           // enable thru filter_mode

// memory interface
`define ECFG_MI_AW   20
`define ECFG_MI_DW   32

`endif

/* rtl/ecfg_pkg.sv */
// link config shared types
`include "ecfg_config.svh"

package ecfg_pkg;

   // ########################################
   // plain vectors
   // ########################################
   typedef logic [`ECFG_MI_AW-1:0]  mi_addr_t;   // full physical address
   typedef logic [`ECFG_MI_DW-1:0]  mi_data_t;   // always full words
   typedef logic [`ECFG_RFAW-1:0]   reg_idx_t;   // word index in group
   typedef logic [3:0]              ctrlmode_t;  // emesh ctrlmode tag
   typedef logic [`ECFG_DOUT_W-1:0] pins_t;      // link pins
   typedef logic [`ECFG_STAT_W-1:0] stat_t;      // sticky flags

   // ########################################
   // structs
   // ########################################
   // one strobe per writable register
   typedef struct packed {
      logic tx_cfg;
      logic tx_dout;
      logic rx_cfg;
   } ecfg_wen_t;

   // read request to the readback stage
   typedef struct packed {
      logic     valid;
      reg_idx_t idx;
   } ecfg_rd_t;

   typedef struct packed {
      logic      enable;
      logic      mmu_enable;
      logic      gpio_enable;   // tx pins forced to dataout
      logic      tp_enable;     // 1/0 test pattern
      ctrlmode_t ctrlmode;
      logic      ctrlmode_bp;
      logic      remap_enable;
   } ecfg_tx_ctrl_t;

   typedef struct packed {
      logic       enable;
      logic       mmu_enable;
      logic       gpio_enable;
      logic [1:0] filter_mode;
   } ecfg_rx_ctrl_t;

endpackage

/* rtl/ecfg_decode.sv */
// memory interface request decode
`include "ecfg_config.svh"

module ecfg_decode #(
   parameter logic [3:0] GROUP = `ECFG_GROUP
) (
   input  logic                mi_en,
   input  logic                mi_we,      // full word writes only
   input  ecfg_pkg::mi_addr_t  mi_addr,
   output ecfg_pkg::ecfg_wen_t wen,
   output ecfg_pkg::ecfg_rd_t  rd
);

   logic               hit;     // request aimed at this group
   logic               wr;
   ecfg_pkg::reg_idx_t idx;

   // ########################################
   // group match and split
   // ########################################
   assign hit = mi_en && (mi_addr[19:16] == GROUP);
   assign wr  = hit && mi_we;
   assign idx = mi_addr[`ECFG_RFAW+1:2];   // word address, byte bits dropped

   // read valid travels with the index
   assign rd.valid = hit && !mi_we;
   assign rd.idx   = idx;

   // ########################################
   // write strobes
   // ########################################
   always_comb begin
      wen = '0;
      if (wr) begin
         case (idx)
            `ECFG_TXCFG:  wen.tx_cfg  = 1'b1;
            `ECFG_TXDOUT: wen.tx_dout = 1'b1;
            `ECFG_RXCFG:  wen.rx_cfg  = 1'b1;
            // status and pin sample are read only
            default: ;
         endcase
      end
   end

endmodule

/* rtl/ecfg_tx.sv */
// transmit config registers
`include "ecfg_config.svh"

module ecfg_tx (
   input  logic                       mi_clk,
   input  logic                       reset,        // hard reset only
   input  ecfg_pkg::ecfg_wen_t        wen,
   input  ecfg_pkg::mi_data_t         mi_din,
   input  ecfg_pkg::stat_t            tx_debug,     // raw flags from tx path
   output ecfg_pkg::ecfg_tx_ctrl_t    tx_ctrl,
   output ecfg_pkg::pins_t            tx_dataout,   // constant pin values
   output logic [`ECFG_TXCFG_W-1:0]   tx_cfg_q,
   output ecfg_pkg::stat_t            tx_stat_q
);

   // ########################################
   // config register
   // ########################################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         tx_cfg_q <= '0;
      end else if (wen.tx_cfg) begin
         tx_cfg_q <= mi_din[`ECFG_TXCFG_W-1:0];   // upper bits dropped
      end
   end

   // field decode
   always_comb begin
      tx_ctrl.enable       = tx_cfg_q[0];
      tx_ctrl.mmu_enable   = tx_cfg_q[1];
      // output mode, 11 is reserved and selects nothing
      tx_ctrl.gpio_enable  = (tx_cfg_q[3:2] == 2'b01);
      tx_ctrl.tp_enable    = (tx_cfg_q[3:2] == 2'b10);
      tx_ctrl.ctrlmode     = tx_cfg_q[7:4];
      tx_ctrl.ctrlmode_bp  = tx_cfg_q[8];           // bypass tag
      tx_ctrl.remap_enable = tx_cfg_q[9];
   end

   // ########################################
   // data-out register
   // ########################################
   // drives the link pins while gpio mode is on
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         tx_dataout <= '0;
      end else if (wen.tx_dout) begin
         tx_dataout <= mi_din[`ECFG_DOUT_W-1:0];
      end
   end

   // ########################################
   // sticky debug
   // ########################################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         tx_stat_q <= '0;
      end else begin
         tx_stat_q <= tx_stat_q | tx_debug;   // set and hold till reset
      end
   end

endmodule

/* rtl/ecfg_rx.sv */
// receive config registers
`include "ecfg_config.svh"

module ecfg_rx (
   input  logic                       mi_clk,
   input  logic                       reset,
   input  ecfg_pkg::ecfg_wen_t        wen,
   input  ecfg_pkg::mi_data_t         mi_din,
   input  ecfg_pkg::stat_t            rx_debug,
   input  ecfg_pkg::pins_t            rx_pins,      // async link pins
   output ecfg_pkg::ecfg_rx_ctrl_t    rx_ctrl,
   output logic [`ECFG_RXCFG_W-1:0]   rx_cfg_q,
   output ecfg_pkg::pins_t            rx_pins_q,    // synced sample
   output ecfg_pkg::stat_t            rx_stat_q
);

   ecfg_pkg::pins_t pins_meta;   // first sync stage

   // ########################################
   // config register
   // ########################################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         rx_cfg_q <= '0;
      end else if (wen.rx_cfg) begin
         rx_cfg_q <= mi_din[`ECFG_RXCFG_W-1:0];
      end
   end

   always_comb begin
      rx_ctrl.enable      = rx_cfg_q[0];
      rx_ctrl.mmu_enable  = rx_cfg_q[1];
      rx_ctrl.gpio_enable = (rx_cfg_q[3:2] == 2'b01);   // other codes unused
      rx_ctrl.filter_mode = rx_cfg_q[5:4];
   end

   // ########################################
   // pin synchronizer
   // ########################################
   // two flops, sample valid 2 edges after pins settle
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         pins_meta <= '0;
         rx_pins_q <= '0;
      end else begin
         pins_meta <= rx_pins;
         rx_pins_q <= pins_meta;
      end
   end

   // sticky debug flags
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         rx_stat_q <= '0;
      end else begin
         rx_stat_q <= rx_stat_q | rx_debug;
      end
   end

endmodule

/* rtl/ecfg_readback.sv */
// register readback port
`include "ecfg_config.svh"

module ecfg_readback (
   input  logic                       mi_clk,
   input  logic                       reset,
   input  ecfg_pkg::ecfg_rd_t         rd,
   input  logic [`ECFG_TXCFG_W-1:0]   tx_cfg_q,
   input  ecfg_pkg::pins_t            tx_dout_q,
   input  ecfg_pkg::stat_t            tx_stat_q,
   input  logic [`ECFG_RXCFG_W-1:0]   rx_cfg_q,
   input  ecfg_pkg::pins_t            rx_pins_q,
   input  ecfg_pkg::stat_t            rx_stat_q,
   output ecfg_pkg::mi_data_t         mi_dout
);

   ecfg_pkg::mi_data_t rd_word;   // selected register, zero extended

   // ########################################
   // select
   // ########################################
   always_comb begin
      case (rd.idx)
         `ECFG_TXCFG:  rd_word = ecfg_pkg::mi_data_t'(tx_cfg_q);   // all 10 bits
         `ECFG_TXDOUT: rd_word = ecfg_pkg::mi_data_t'(tx_dout_q);
         `ECFG_TXSTAT: rd_word = ecfg_pkg::mi_data_t'(tx_stat_q);
         `ECFG_RXCFG:  rd_word = ecfg_pkg::mi_data_t'(rx_cfg_q);
         `ECFG_RXGPIO: rd_word = ecfg_pkg::mi_data_t'(rx_pins_q);
         `ECFG_RXSTAT: rd_word = ecfg_pkg::mi_data_t'(rx_stat_q);
         default:      rd_word = '0;   // unmapped reads as zero
      endcase
   end

   // ########################################
   // output register
   // ########################################
   // one cycle read latency, holds between reads
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         mi_dout <= '0;
      end else if (rd.valid) begin
         mi_dout <= rd_word;
      end
   end

endmodule

/* rtl/ecfg_top.sv */
// link config block top
`include "ecfg_config.svh"

module ecfg_top (
   input  logic                    mi_clk,
   input  logic                    reset,
   input  logic                    mi_en,
   input  logic                    mi_we,
   input  ecfg_pkg::mi_addr_t      mi_addr,
   input  ecfg_pkg::mi_data_t      mi_din,
   output ecfg_pkg::mi_data_t      mi_dout,
   output ecfg_pkg::ecfg_tx_ctrl_t tx_ctrl,
   output ecfg_pkg::pins_t         tx_dataout,
   input  ecfg_pkg::stat_t         tx_debug,
   input  ecfg_pkg::stat_t         rx_debug,
   input  ecfg_pkg::pins_t         rx_pins,
   output ecfg_pkg::ecfg_rx_ctrl_t rx_ctrl
);

   ecfg_pkg::ecfg_wen_t      wen;
   ecfg_pkg::ecfg_rd_t       rd;
   logic [`ECFG_TXCFG_W-1:0] tx_cfg_q;
   ecfg_pkg::stat_t          tx_stat_q;
   logic [`ECFG_RXCFG_W-1:0] rx_cfg_q;
   ecfg_pkg::pins_t          rx_pins_q;
   ecfg_pkg::stat_t          rx_stat_q;

   // ########################################
   // decode, banks, readback
   // ########################################
   ecfg_decode #(.GROUP(`ECFG_GROUP)) u_decode (
      .mi_en   (mi_en),
      .mi_we   (mi_we),
      .mi_addr (mi_addr),
      .wen     (wen),
      .rd      (rd)
   );

   ecfg_tx u_tx (
      .mi_clk     (mi_clk),
      .reset      (reset),
      .wen        (wen),
      .mi_din     (mi_din),
      .tx_debug   (tx_debug),
      .tx_ctrl    (tx_ctrl),
      .tx_dataout (tx_dataout),
      .tx_cfg_q   (tx_cfg_q),
      .tx_stat_q  (tx_stat_q)
   );

   ecfg_rx u_rx (
      .mi_clk    (mi_clk),
      .reset     (reset),
      .wen       (wen),
      .mi_din    (mi_din),
      .rx_debug  (rx_debug),
      .rx_pins   (rx_pins),
      .rx_ctrl   (rx_ctrl),
      .rx_cfg_q  (rx_cfg_q),
      .rx_pins_q (rx_pins_q),
      .rx_stat_q (rx_stat_q)
   );

   // data-out register read back from the tx pin output
   ecfg_readback u_readback (
      .mi_clk    (mi_clk),
      .reset     (reset),
      .rd        (rd),
      .tx_cfg_q  (tx_cfg_q),
      .tx_dout_q (tx_dataout),
      .tx_stat_q (tx_stat_q),
      .rx_cfg_q  (rx_cfg_q),
      .rx_pins_q (rx_pins_q),
      .rx_stat_q (rx_stat_q),
      .mi_dout   (mi_dout)
   );

endmodule

/* tests/ecfg_chk.sv */
// config block property checks
`include "ecfg_config.svh"

module ecfg_chk (
   input logic                    mi_clk,
   input logic                    reset,
   input logic                    mi_en,
   input logic                    mi_we,
   input ecfg_pkg::mi_addr_t      mi_addr,
   input ecfg_pkg::mi_data_t      mi_dout,
   input ecfg_pkg::ecfg_tx_ctrl_t tx_ctrl,
   input ecfg_pkg::pins_t         tx_dataout,
   input ecfg_pkg::ecfg_rx_ctrl_t rx_ctrl
);
   timeunit 1ns;
   timeprecision 100ps;

   logic rd_req;   // in-group read at this edge
   logic cfg_wr;   // in-group write to tx config
   assign rd_req = mi_en && !mi_we && (mi_addr[19:16] == `ECFG_GROUP);
   assign cfg_wr = mi_en && mi_we && (mi_addr[19:16] == `ECFG_GROUP)
                   && (mi_addr[`ECFG_RFAW+1:2] == `ECFG_TXCFG);

   // ########################################
   // properties
   // ########################################
   reset_idle: assert property (@(posedge mi_clk)
      $past(reset) |-> (tx_ctrl == '0 && rx_ctrl == '0 && tx_dataout == '0 && mi_dout == '0))
      else $error("outputs not cleared by reset");

   // only an in-group read moves mi_dout
   dout_hold: assert property (@(posedge mi_clk) disable iff (reset)
      (!$past(rd_req) && !$past(reset)) |-> $stable(mi_dout))
      else $error("mi_dout changed without a read");

   // tx decode only moves after a config write
   cfg_hold: assert property (@(posedge mi_clk) disable iff (reset)
      (!$past(cfg_wr) && !$past(reset)) |-> $stable(tx_ctrl))
      else $error("tx_ctrl changed without a config write");

endmodule

bind ecfg_top ecfg_chk u_chk (
   .mi_clk     (mi_clk),
   .reset      (reset),
   .mi_en      (mi_en),
   .mi_we      (mi_we),
   .mi_addr    (mi_addr),
   .mi_dout    (mi_dout),
   .tx_ctrl    (tx_ctrl),
   .tx_dataout (tx_dataout),
   .rx_ctrl    (rx_ctrl)
);

/* tests/ecfg_tb.sv */
// config block testbench
module ecfg_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD = 20;   // mi_clk period, ns
   localparam int SKEW   = 2;    // drive delay after the edge

   // one line of the vector file
   typedef struct packed {
      logic                    en;
      logic                    we;
      ecfg_pkg::mi_addr_t      addr;
      ecfg_pkg::mi_data_t      data;
      ecfg_pkg::stat_t         tx_dbg;
      ecfg_pkg::stat_t         rx_dbg;
      ecfg_pkg::pins_t         pins;
      ecfg_pkg::mi_data_t      exp_dout;
      ecfg_pkg::ecfg_tx_ctrl_t exp_tx;
      ecfg_pkg::pins_t         exp_pins;   // tx_dataout
      ecfg_pkg::ecfg_rx_ctrl_t exp_rx;
   } vec_t;

   logic                    mi_clk;
   logic                    reset;
   logic                    mi_en;
   logic                    mi_we;
   ecfg_pkg::mi_addr_t      mi_addr;
   ecfg_pkg::mi_data_t      mi_din;
   ecfg_pkg::mi_data_t      mi_dout;
   ecfg_pkg::ecfg_tx_ctrl_t tx_ctrl;
   ecfg_pkg::pins_t         tx_dataout;
   ecfg_pkg::stat_t         tx_debug;
   ecfg_pkg::stat_t         rx_debug;
   ecfg_pkg::pins_t         rx_pins;
   ecfg_pkg::ecfg_rx_ctrl_t rx_ctrl;

   vec_t  vecs[$];
   string names[$];
   int    n_pass;
   int    n_fail;
   bit    loaded;     // vector count known, watchdog may start

   ecfg_top uut (.*);

   initial begin
      mi_clk = 1'b0;
      forever #(PERIOD / 2) mi_clk = ~mi_clk;
   end

   // ########################################
   // vector file
   // ########################################
   task automatic load_vectors();
      int          fd;
      int          n;
      string       line;
      string       name;
      string       op;
      logic [31:0] addr, data, txd, rxd, pins;
      logic [31:0] e_dout, e_tx, e_pins, e_rx;
      vec_t        v;
      fd = $fopen("tests/ecfg_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open tests/ecfg_input.txt");
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#") continue;   // blank or column notes
         n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", name, op,
                     addr, data, txd, rxd, pins, e_dout, e_tx, e_pins, e_rx);
         if (n != 11) begin
            $display("malformed vector line: %s", line);
            n_fail++;
            continue;
         end
         v.en       = (op != "I");   // idle drops mi_en
         v.we       = (op == "W");
         v.addr     = addr[19:0];
         v.data     = data;
         v.tx_dbg   = txd[2:0];
         v.rx_dbg   = rxd[2:0];
         v.pins     = pins[8:0];
         v.exp_dout = e_dout;
         v.exp_tx   = e_tx[9:0];
         v.exp_pins = e_pins[8:0];
         v.exp_rx   = e_rx[4:0];
         vecs.push_back(v);
         names.push_back(name);
      end
      $fclose(fd);
   endtask

   task automatic drive_vector(input vec_t v);
      mi_en    = v.en;
      mi_we    = v.we;
      mi_addr  = v.addr;
      mi_din   = v.data;
      tx_debug = v.tx_dbg;   // one cycle pulse per line
      rx_debug = v.rx_dbg;
      rx_pins  = v.pins;
   endtask

   // outputs one cycle after the request was sampled
   task automatic check_vector(input string name, input vec_t v);
      bit ok;
      ok = 1'b1;
      assert (mi_dout === v.exp_dout) else begin
         $display("Error %s: mi_dout expected %h actual %h", name, v.exp_dout, mi_dout);
         ok = 1'b0;
      end
      assert (tx_ctrl === v.exp_tx) else begin
         $display("Error %s: tx_ctrl expected %h actual %h", name, v.exp_tx, tx_ctrl);
         ok = 1'b0;
      end
      assert (tx_dataout === v.exp_pins) else begin
         $display("Error %s: tx_dataout expected %h actual %h", name, v.exp_pins,
                  tx_dataout);
         ok = 1'b0;
      end
      assert (rx_ctrl === v.exp_rx) else begin
         $display("Error %s: rx_ctrl expected %h actual %h", name, v.exp_rx, rx_ctrl);
         ok = 1'b0;
      end
      if (ok) begin
         n_pass++;
         $display("%-12s pass", name);
      end else begin
         n_fail++;
         $display("%-12s FAIL", name);
      end
   endtask

   // ########################################
   // main sequence
   // ########################################
   initial begin : run
      int i;
      reset    = 1'b1;
      mi_en    = 1'b0;
      mi_we    = 1'b0;
      mi_addr  = '0;
      mi_din   = '0;
      tx_debug = '0;
      rx_debug = '0;
      rx_pins  = '0;
      n_pass   = 0;
      n_fail   = 0;
      load_vectors();
      if (vecs.size() == 0) begin
         $display("no test vectors loaded");
         n_fail++;
      end
      loaded = 1'b1;
      repeat (2) @(posedge mi_clk);
      #SKEW reset = 1'b0;
      // drive line i, check line i-1 just before the edge
      for (i = 0; i <= vecs.size(); i++) begin
         if (i < vecs.size()) begin
            drive_vector(vecs[i]);
         end else begin
            mi_en    = 1'b0;   // trailing idle cycle
            tx_debug = '0;
            rx_debug = '0;
         end
         #(PERIOD - 2 * SKEW);
         if (i > 0) check_vector(names[i-1], vecs[i-1]);
         @(posedge mi_clk);
         #SKEW;
      end
      $display("%0d tests passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // vectors plus 10 cycles margin
   initial begin : watchdog
      wait (loaded);
      #((vecs.size() + 10) * PERIOD);
      $display("timeout, vectors did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule

/* tests/ecfg_input.txt */
# name op addr data tx_dbg rx_dbg rx_pins  exp: mi_dout tx_ctrl tx_dataout rx_ctrl
# op W write, R read, I idle; hex values; expected one cycle after the request
rst_txcfg   R 00000 00000000 0 0 000 00000000 000 000 00
rst_txdout  R 00004 00000000 0 0 000 00000000 000 000 00
rst_txstat  R 00008 00000000 0 0 000 00000000 000 000 00
rst_rxcfg   R 00010 00000000 0 0 000 00000000 000 000 00
rst_rxgpio  R 00014 00000000 0 0 000 00000000 000 000 00
rst_rxstat  R 00018 00000000 0 0 000 00000000 000 000 00
tx_mode00   W 00000 ABCDE351 0 0 000 00000000 217 000 00
tx_mode01   W 00000 00000086 0 0 000 00000000 1A0 000 00
tx_mode10   W 00000 FFFFF2FB 0 0 000 00000000 37D 000 00
tx_rd10     R 00000 00000000 0 0 000 000002FB 37D 000 00
tx_mode11   W 00000 0000010E 0 0 000 000002FB 102 000 00
rx_cfg_all  W 00010 FFFFFFFF 0 0 000 000002FB 102 000 1B
dout_all    W 00004 FFFFFFFF 0 0 000 000002FB 102 1FF 1B
rd_rxcfg    R 00010 00000000 0 0 000 0000003F 102 1FF 1B
ro_txstat   W 00008 FFFFFFFF 0 0 000 0000003F 102 1FF 1B
ro_rxgpio   W 00014 FFFFFFFF 0 0 000 0000003F 102 1FF 1B
ro_rxstat   W 00018 FFFFFFFF 0 0 000 0000003F 102 1FF 1B
rd_txdout   R 00004 00000000 0 0 000 000001FF 102 1FF 1B
grp_wr      W 10000 FFFFFFFF 0 0 000 000001FF 102 1FF 1B
grp_rd      R 20000 00000000 0 0 000 000001FF 102 1FF 1B
unmapped    R 0000C 00000000 0 0 000 00000000 102 1FF 1B
tx_dbg1     I 00000 00000000 2 0 0A5 00000000 102 1FF 1B
rx_dbg2     I 00000 00000000 0 4 0A5 00000000 102 1FF 1B
tx_dbg0     I 00000 00000000 1 0 0A5 00000000 102 1FF 1B
rd_txstat   R 00008 00000000 0 0 0A5 00000003 102 1FF 1B
rd_rxstat   R 00018 00000000 0 0 0A5 00000004 102 1FF 1B
rd_rxgpio   R 00014 00000000 0 0 0A5 000000A5 102 1FF 1B
b2b_wr      W 00010 00000025 0 0 0A5 000000A5 102 1FF 16
b2b_rd      R 00010 00000000 0 0 0A5 00000025 102 1FF 16
run_rd0     R 00000 00000000 0 0 0A5 0000010E 102 1FF 16
run_rd1     R 00004 00000000 0 0 0A5 000001FF 102 1FF 16
run_rd2     R 00008 00000000 0 0 0A5 00000003 102 1FF 16

/* tb.f */
+incdir+rtl
rtl/ecfg_pkg.sv
rtl/ecfg_decode.sv
rtl/ecfg_tx.sv
rtl/ecfg_rx.sv
rtl/ecfg_readback.sv
rtl/ecfg_top.sv
tests/ecfg_chk.sv
tests/ecfg_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = ecfg_tb
FILELIST  = tb.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
